// ==== include/ibuf_defines.svh ====
`ifndef IBUF_DEFINES_SVH
`define IBUF_DEFINES_SVH

// one cache line per slot
`define IBUF_LINE_BITS 128

// four slots in a 64-byte ring, even lines in 0 and 2
`define IBUF_NUM_SLOTS 4

// byte pointer into the ring
`define IBUF_BIP_BITS 6

`define IBUF_FIP_BITS 2  // fetch pointer low bits, one slot

// decoder window
`define IBUF_WIN_BYTES 16
`define IBUF_CNT_BITS 5  // holds 0 to 16

`endif

// ==== src/fetch_pkg.sv ====
`include "ibuf_defines.svh"

package fetch_pkg;

    // control-flow events seen by fetch1, one-cycle strobe
    typedef enum logic [1:0] {
        CF_NONE    = 2'd0,
        CF_BRANCH  = 2'd1,
        CF_RESTEER = 2'd2,
        CF_INIT    = 2'd3
    } cf_event_e;

    // fetch1 outputs of the split even/odd cache
    typedef struct packed {
        logic [`IBUF_LINE_BITS-1:0] line_even;
        logic [`IBUF_LINE_BITS-1:0] line_odd;
        logic [`IBUF_FIP_BITS-1:0]  fip_even;   // target slot for the even line
        logic [`IBUF_FIP_BITS-1:0]  fip_odd;    // target slot for the odd line
        logic                       miss_even;
        logic                       miss_odd;
        logic                       wait_even;  // way stall
        logic                       wait_odd;
        cf_event_e                  cf_event;
    } fetch1_t;

    // byte pointers from the decoder side
    typedef struct packed {
        logic [`IBUF_BIP_BITS-1:0] new_bip;
        logic [`IBUF_BIP_BITS-1:0] old_bip;
    } fetch2_t;

endpackage

// ==== src/ibuf_pkg.sv ====
`include "ibuf_defines.svh"

package ibuf_pkg;

    // how many cache lines the buffer accepts this cycle
    typedef enum logic [1:0] {
        LD_NONE = 2'd0,
        LD_ODD  = 2'd1,
        LD_EVEN = 2'd2,
        LD_BOTH = 2'd3
    } load_mode_e;

    // one bit per slot
    typedef logic [`IBUF_NUM_SLOTS-1:0] slot_mask_t;

    // slot 0 sits in the low bits, so byte b of the ring is bits 8b+7:8b
    typedef logic [`IBUF_NUM_SLOTS-1:0][`IBUF_LINE_BITS-1:0] slot_array_t;

    // decoder window starting at the byte pointer
    typedef struct packed {
        logic [`IBUF_WIN_BYTES-1:0][7:0] bytes;
        logic [`IBUF_CNT_BITS-1:0]       count;  // leading valid bytes
    } window_t;

endpackage

// ==== src/ibuf_load_ctrl.sv ====
`timescale 1ns/1ps

module ibuf_load_ctrl (
    input  logic                 clk,
    input  logic                 rst_i,
    input  fetch_pkg::cf_event_e cf_event_i,
    input  logic                 miss_even_i,
    input  logic                 miss_odd_i,
    input  ibuf_pkg::slot_mask_t valid_i,
    output ibuf_pkg::load_mode_e mode_o
);

    ibuf_pkg::slot_mask_t free;
    logic                 pair_free;
    logic                 even_free;
    logic                 odd_free;
    logic                 cf;
    logic                 ld_reg;
    ibuf_pkg::load_mode_e next_mode;
    ibuf_pkg::load_mode_e mode_q;

    assign free = ~valid_i;

    // two neighbouring holes around the ring take a full even/odd pair
    assign pair_free = (free[0] & free[1]) |
                       (free[1] & free[2]) |
                       (free[2] & free[3]) |
                       (free[3] & free[0]);
    assign even_free = free[0] | free[2];
    assign odd_free  = free[1] | free[3];

    always_comb begin
        if (pair_free) begin
            next_mode = ibuf_pkg::LD_BOTH;
        end else if (even_free) begin
            next_mode = ibuf_pkg::LD_EVEN;
        end else if (odd_free) begin
            next_mode = ibuf_pkg::LD_ODD;
        end else begin
            next_mode = ibuf_pkg::LD_NONE;
        end
    end

    assign cf     = (cf_event_i != fetch_pkg::CF_NONE);
    assign ld_reg = ~miss_even_i & ~miss_odd_i;  // a miss on either side freezes the mode

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mode_q <= ibuf_pkg::LD_BOTH;  // empty buffer wants both lines
        end else if (ld_reg) begin
            if (cf) begin
                mode_q <= ibuf_pkg::LD_BOTH;
            end else begin
                mode_q <= next_mode;
            end
        end
    end

    // a redirect refills both sides right away, whatever is registered
    assign mode_o = cf ? ibuf_pkg::LD_BOTH : mode_q;

endmodule

// ==== src/ibuf_load_select.sv ====
`timescale 1ns/1ps

`include "ibuf_defines.svh"

module ibuf_load_select (
    input  ibuf_pkg::load_mode_e mode_i,
    input  fetch_pkg::fetch1_t   fetch1_i,
    input  fetch_pkg::fetch2_t   fetch2_i,
    output ibuf_pkg::slot_mask_t load_mask_o,
    output ibuf_pkg::slot_mask_t inval_mask_o,
    output logic                 even_loaded_o,
    output logic                 odd_loaded_o
);

    ibuf_pkg::slot_mask_t      even_hit;
    ibuf_pkg::slot_mask_t      odd_hit;
    ibuf_pkg::slot_mask_t      load_mask;
    logic [`IBUF_FIP_BITS-1:0] even_next;
    logic [`IBUF_FIP_BITS-1:0] odd_next;
    logic                      adjacent;
    logic                      want_even;
    logic                      want_odd;
    logic                      go_even;
    logic                      go_odd;
    logic                      wrapped;
    logic [1:0]                old_slot;

    // one-hot slot decode, each pointer only reaches slots of its own parity
    always_comb begin
        even_hit = '0;
        odd_hit  = '0;
        for (int s = 0; s < `IBUF_NUM_SLOTS; s++) begin
            if (s % 2 == 0) begin
                even_hit[s] = (fetch1_i.fip_even == `IBUF_FIP_BITS'(s));
            end else begin
                odd_hit[s] = (fetch1_i.fip_odd == `IBUF_FIP_BITS'(s));
            end
        end
    end

    // the pair must sit next to each other, 3-0 counts as well
    assign even_next = fetch1_i.fip_even + `IBUF_FIP_BITS'(1);
    assign odd_next  = fetch1_i.fip_odd + `IBUF_FIP_BITS'(1);
    assign adjacent  = (even_next == fetch1_i.fip_odd) | (odd_next == fetch1_i.fip_even);

    always_comb begin
        want_even = 1'b0;
        want_odd  = 1'b0;
        case (mode_i)
            ibuf_pkg::LD_EVEN: want_even = 1'b1;
            ibuf_pkg::LD_ODD:  want_odd  = 1'b1;
            ibuf_pkg::LD_BOTH: begin
                want_even = adjacent;
                want_odd  = adjacent;
            end
            default: begin
                want_even = 1'b0;
                want_odd  = 1'b0;
            end
        endcase
    end

    // miss or way stall holds that side only
    assign go_even = want_even & ~fetch1_i.miss_even & ~fetch1_i.wait_even;
    assign go_odd  = want_odd & ~fetch1_i.miss_odd & ~fetch1_i.wait_odd;

    assign load_mask = ({`IBUF_NUM_SLOTS{go_even}} & even_hit) |
                       ({`IBUF_NUM_SLOTS{go_odd}} & odd_hit);

    // byte offset went backwards, so the pointer has left slot old_bip[5:4]
    assign wrapped  = (fetch2_i.old_bip[3:0] > fetch2_i.new_bip[3:0]);
    assign old_slot = fetch2_i.old_bip[5:4];

    always_comb begin
        inval_mask_o = '0;
        for (int s = 0; s < `IBUF_NUM_SLOTS; s++) begin
            inval_mask_o[s] = wrapped & (old_slot == 2'(s));
        end
    end

    assign load_mask_o   = load_mask;
    assign even_loaded_o = load_mask[0] | load_mask[2];
    assign odd_loaded_o  = load_mask[1] | load_mask[3];

endmodule

// ==== src/ibuf_slots.sv ====
`timescale 1ns/1ps

`include "ibuf_defines.svh"

module ibuf_slots (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [`IBUF_LINE_BITS-1:0] line_even_i,
    input  logic [`IBUF_LINE_BITS-1:0] line_odd_i,
    input  ibuf_pkg::slot_mask_t       load_mask_i,
    input  ibuf_pkg::slot_mask_t       inval_mask_i,
    output ibuf_pkg::slot_array_t      slots_o,
    output ibuf_pkg::slot_mask_t       valid_o
);

    ibuf_pkg::slot_array_t slots_q;
    ibuf_pkg::slot_mask_t  valid_q;
    ibuf_pkg::slot_mask_t  take;

    // invalidate wins, the slot keeps its old line
    assign take = load_mask_i & ~inval_mask_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            slots_q <= '0;
            valid_q <= '0;
        end else begin
            for (int s = 0; s < `IBUF_NUM_SLOTS; s++) begin
                if (take[s]) begin
                    // slots 0 and 2 are fed from the even bank
                    if (s % 2 == 0) begin
                        slots_q[s] <= line_even_i;
                    end else begin
                        slots_q[s] <= line_odd_i;
                    end
                end

                if (inval_mask_i[s]) begin
                    valid_q[s] <= 1'b0;
                end else if (load_mask_i[s]) begin
                    valid_q[s] <= 1'b1;
                end
            end
        end
    end

    assign slots_o = slots_q;
    assign valid_o = valid_q;

endmodule

// ==== src/ibuf_window.sv ====
`timescale 1ns/1ps

`include "ibuf_defines.svh"

module ibuf_window (
    input  ibuf_pkg::slot_array_t     slots_i,
    input  ibuf_pkg::slot_mask_t      valid_i,
    input  logic [`IBUF_BIP_BITS-1:0] bip_i,
    output ibuf_pkg::window_t         window_o
);

    localparam int RING_BYTES = `IBUF_NUM_SLOTS * `IBUF_LINE_BITS / 8;

    logic [RING_BYTES-1:0][7:0]      ring;
    logic [`IBUF_WIN_BYTES-1:0][7:0] bytes;
    logic [`IBUF_BIP_BITS-1:0]       idx;
    logic [1:0]                      head_slot;
    logic [1:0]                      next_slot;
    logic [`IBUF_CNT_BITS-1:0]       head_bytes;
    logic [`IBUF_CNT_BITS-1:0]       count;

    assign ring = slots_i;  // same bits seen as 64 bytes

    // rotate, pointer arithmetic wraps at 64
    always_comb begin
        idx   = '0;
        bytes = '0;
        for (int k = 0; k < `IBUF_WIN_BYTES; k++) begin
            idx      = bip_i + `IBUF_BIP_BITS'(k);
            bytes[k] = ring[idx];
        end
    end

    assign head_slot  = bip_i[5:4];
    assign next_slot  = head_slot + 2'd1;  // 3 rolls over to 0
    assign head_bytes = `IBUF_CNT_BITS'(`IBUF_WIN_BYTES) - {1'b0, bip_i[3:0]};

    // the window spans at most two slots
    always_comb begin
        if (!valid_i[head_slot]) begin
            count = '0;
        end else if (valid_i[next_slot]) begin
            count = `IBUF_CNT_BITS'(`IBUF_WIN_BYTES);
        end else begin
            count = head_bytes;  // a full 16 when bip sits on a line start
        end
    end

    assign window_o.bytes = bytes;
    assign window_o.count = count;

endmodule

// ==== src/ibuf_top.sv ====
`timescale 1ns/1ps

module ibuf_top (
    input  logic                  clk,
    input  logic                  rst_i,
    input  fetch_pkg::fetch1_t    fetch1_i,
    input  fetch_pkg::fetch2_t    fetch2_i,
    output ibuf_pkg::window_t     window_o,
    output ibuf_pkg::slot_mask_t  valid_o,
    output logic                  even_loaded_o,
    output logic                  odd_loaded_o
);

    ibuf_pkg::load_mode_e  mode;
    ibuf_pkg::slot_mask_t  load_mask;
    ibuf_pkg::slot_mask_t  inval_mask;
    ibuf_pkg::slot_array_t slots;

    // decode
    ibuf_load_ctrl u_load_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .cf_event_i  (fetch1_i.cf_event),
        .miss_even_i (fetch1_i.miss_even),
        .miss_odd_i  (fetch1_i.miss_odd),
        .valid_i     (valid_o),
        .mode_o      (mode)
    );

    // execute
    ibuf_load_select u_load_select (
        .mode_i        (mode),
        .fetch1_i      (fetch1_i),
        .fetch2_i      (fetch2_i),
        .load_mask_o   (load_mask),
        .inval_mask_o  (inval_mask),
        .even_loaded_o (even_loaded_o),
        .odd_loaded_o  (odd_loaded_o)
    );

    ibuf_slots u_slots (
        .clk          (clk),
        .rst_i        (rst_i),
        .line_even_i  (fetch1_i.line_even),
        .line_odd_i   (fetch1_i.line_odd),
        .load_mask_i  (load_mask),
        .inval_mask_i (inval_mask),
        .slots_o      (slots),
        .valid_o      (valid_o)
    );

    // result, window follows the decoder's new byte pointer
    ibuf_window u_window (
        .slots_i  (slots),
        .valid_i  (valid_o),
        .bip_i    (fetch2_i.new_bip),
        .window_o (window_o)
    );

endmodule

// ==== sim/ibuf_tb.sv ====
`timescale 1ns/1ps

`include "ibuf_defines.svh"

module ibuf_tb;

    localparam int  RST_LIMIT  = 20;    // cycles
    localparam int  EDGE_LIMIT = 200;   // ns
    localparam time RUN_LIMIT  = 20000;

    typedef struct packed {
        fetch_pkg::fetch1_t   f1;
        fetch_pkg::fetch2_t   f2;
        ibuf_pkg::slot_mask_t exp_valid;
        logic                 exp_even;
        logic                 exp_odd;
    } row_t;

    logic                 clk;
    logic                 rst_i;
    fetch_pkg::fetch1_t   fetch1;
    fetch_pkg::fetch2_t   fetch2;
    ibuf_pkg::window_t    window_o;
    ibuf_pkg::slot_mask_t valid_o;
    logic                 even_loaded_o;
    logic                 odd_loaded_o;

    row_t  rows[$];
    string names[$];
    int    errors;
    int    passed;
    int    failed;
    bit    edge_seen;
    int    edge_count;  // rising edges so far

    // reference ring that follows the load, invalidate and mode rules
    ibuf_pkg::slot_array_t m_ring;
    ibuf_pkg::slot_mask_t  m_valid;
    ibuf_pkg::load_mode_e  m_mode;

    ibuf_top dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .fetch1_i      (fetch1),
        .fetch2_i      (fetch2),
        .window_o      (window_o),
        .valid_o       (valid_o),
        .even_loaded_o (even_loaded_o),
        .odd_loaded_o  (odd_loaded_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    initial begin
        rst_i  = 1'b1;
        fetch1 = '0;
        fetch2 = '0;
        repeat (8) @(posedge clk);
        #2 rst_i = 1'b0;
    end

    initial begin
        #(RUN_LIMIT);
        $display("simulation ran past %0t ns without finishing", RUN_LIMIT);
        $display("test failed");
        $finish;
    end

    // stall is {miss_even, miss_odd, wait_even, wait_odd}
    task automatic add_row(input string name, input int fe, input int fo, input logic [3:0] stall,
                           input fetch_pkg::cf_event_e cf, input int nb, input int ob,
                           input ibuf_pkg::slot_mask_t ev, input bit ee, input bit eo);
        row_t r;
        r.f1.line_even = {$urandom, $urandom, $urandom, $urandom};
        r.f1.line_odd  = {$urandom, $urandom, $urandom, $urandom};
        r.f1.fip_even  = `IBUF_FIP_BITS'(fe);
        r.f1.fip_odd   = `IBUF_FIP_BITS'(fo);
        {r.f1.miss_even, r.f1.miss_odd, r.f1.wait_even, r.f1.wait_odd} = stall;
        r.f1.cf_event  = cf;
        r.f2.new_bip   = `IBUF_BIP_BITS'(nb);
        r.f2.old_bip   = `IBUF_BIP_BITS'(ob);
        r.exp_valid    = ev;
        r.exp_even     = ee;
        r.exp_odd      = eo;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic build_table();
        add_row("startup pair",  0, 1, 4'b0000, fetch_pkg::CF_NONE,    0,  0, 4'b0011, 1, 1);
        add_row("fill 2 and 3",  2, 3, 4'b0000, fetch_pkg::CF_NONE,    4,  4, 4'b1111, 1, 1);
        add_row("mode lag",      0, 1, 4'b0000, fetch_pkg::CF_NONE,    8,  8, 4'b1111, 1, 1);
        add_row("full, none",    0, 1, 4'b0000, fetch_pkg::CF_NONE,    8,  8, 4'b1111, 0, 0);
        add_row("inval slot 0",  0, 1, 4'b0000, fetch_pkg::CF_NONE,   16, 12, 4'b1110, 0, 0);
        add_row("hole, lag",     0, 1, 4'b0000, fetch_pkg::CF_NONE,   16, 16, 4'b1110, 0, 0);
        add_row("even hole",     0, 3, 4'b0000, fetch_pkg::CF_NONE,   32, 20, 4'b1101, 1, 0);
        add_row("even again",    2, 1, 4'b0000, fetch_pkg::CF_NONE,   32, 32, 4'b1101, 1, 0);
        add_row("odd hole",      0, 1, 4'b0000, fetch_pkg::CF_NONE,   40, 40, 4'b1111, 0, 1);
        add_row("odd miss",      2, 3, 4'b0100, fetch_pkg::CF_NONE,   48, 44, 4'b1011, 0, 0);
        add_row("mode frozen",   2, 3, 4'b0000, fetch_pkg::CF_NONE,   48, 48, 4'b1011, 0, 1);
        add_row("even wait",     2, 3, 4'b0010, fetch_pkg::CF_NONE,   24, 24, 4'b1011, 0, 0);
        add_row("after wait",    2, 3, 4'b0000, fetch_pkg::CF_NONE,   60, 60, 4'b1111, 1, 0);
        add_row("drain to none", 0, 1, 4'b0000, fetch_pkg::CF_NONE,   60, 60, 4'b1111, 1, 0);
        add_row("resteer",       2, 3, 4'b0000, fetch_pkg::CF_RESTEER, 2,  2, 4'b1111, 1, 1);
        add_row("cf lag",        0, 1, 4'b0000, fetch_pkg::CF_NONE,    2,  2, 4'b1111, 1, 1);
        add_row("branch 3-0",    0, 3, 4'b0000, fetch_pkg::CF_BRANCH, 10, 10, 4'b1111, 1, 1);
        add_row("inval on load", 0, 1, 4'b0000, fetch_pkg::CF_NONE,   17, 14, 4'b1110, 1, 1);
        add_row("window at 56",  0, 1, 4'b0000, fetch_pkg::CF_NONE,   56, 56, 4'b1110, 0, 0);
        add_row("init even miss", 0, 1, 4'b1000, fetch_pkg::CF_INIT,   0,  0, 4'b1110, 0, 1);
        add_row("held mode",     0, 1, 4'b0000, fetch_pkg::CF_NONE,    8,  8, 4'b1111, 1, 0);
    endtask

    function automatic ibuf_pkg::load_mode_e next_mode_of(input ibuf_pkg::slot_mask_t v);
        bit pair;
        pair = 1'b0;
        for (int s = 0; s < `IBUF_NUM_SLOTS; s++) begin
            if (!v[s] && !v[(s + 1) % `IBUF_NUM_SLOTS]) pair = 1'b1;
        end
        if (pair) return ibuf_pkg::LD_BOTH;
        if (!v[0] || !v[2]) return ibuf_pkg::LD_EVEN;
        if (!v[1] || !v[3]) return ibuf_pkg::LD_ODD;
        return ibuf_pkg::LD_NONE;
    endfunction

    // one clock edge of the reference ring
    task automatic model_step(input row_t r);
        ibuf_pkg::load_mode_e eff;
        ibuf_pkg::slot_mask_t ld;
        ibuf_pkg::slot_mask_t inv;
        bit                   cf;
        bit                   adj;
        cf  = (r.f1.cf_event != fetch_pkg::CF_NONE);
        eff = cf ? ibuf_pkg::LD_BOTH : m_mode;
        adj = ((int'(r.f1.fip_even) + 1) % 4 == int'(r.f1.fip_odd)) ||
              ((int'(r.f1.fip_odd) + 1) % 4 == int'(r.f1.fip_even));
        ld  = '0;
        inv = '0;
        if ((eff == ibuf_pkg::LD_EVEN || (eff == ibuf_pkg::LD_BOTH && adj)) &&
            !r.f1.miss_even && !r.f1.wait_even) ld[r.f1.fip_even] = 1'b1;
        if ((eff == ibuf_pkg::LD_ODD || (eff == ibuf_pkg::LD_BOTH && adj)) &&
            !r.f1.miss_odd && !r.f1.wait_odd) ld[r.f1.fip_odd] = 1'b1;
        if (r.f2.old_bip[3:0] > r.f2.new_bip[3:0]) inv[r.f2.old_bip[5:4]] = 1'b1;
        if (!r.f1.miss_even && !r.f1.miss_odd) begin
            m_mode = cf ? ibuf_pkg::LD_BOTH : next_mode_of(m_valid);
        end
        for (int s = 0; s < `IBUF_NUM_SLOTS; s++) begin
            if (inv[s]) begin
                m_valid[s] = 1'b0;   // line stays and only the valid bit goes
            end else if (ld[s]) begin
                m_valid[s] = 1'b1;
                m_ring[s]  = (s % 2 == 0) ? r.f1.line_even : r.f1.line_odd;
            end
        end
    endtask

    function automatic ibuf_pkg::window_t expect_window(input logic [`IBUF_BIP_BITS-1:0] bip);
        ibuf_pkg::window_t w;
        int                pos;
        bit                hole;
        w    = '0;
        hole = 1'b0;
        for (int k = 0; k < `IBUF_WIN_BYTES; k++) begin
            pos        = (int'(bip) + k) % 64;
            w.bytes[k] = m_ring[pos / 16][(pos % 16) * 8 +: 8];
            if (!m_valid[pos / 16]) hole = 1'b1;
            if (!hole) w.count = w.count + 1'b1;
        end
        return w;
    endfunction

    task automatic check_mask(input string name, input ibuf_pkg::slot_mask_t exp,
                              input ibuf_pkg::slot_mask_t act);
        if (act !== exp) begin
            $display("ERROR %0t ns %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_window(input string name, input ibuf_pkg::window_t exp,
                                input ibuf_pkg::window_t act);
        if (act !== exp) begin
            $display("ERROR %0t ns %s expected %h/%0d got %h/%0d", $time, name,
                     exp.bytes, exp.count, act.bytes, act.count);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %0t ns %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // returns 1 ns after the next rising edge
    task automatic wait_edge();
        int start;
        int waited;
        start     = edge_count;
        waited    = 0;
        edge_seen = 1'b0;
        while (!edge_seen && waited < EDGE_LIMIT) begin
            #1;
            waited++;
            edge_seen = (edge_count != start);
        end
    endtask

    initial begin
        int n;
        int row_err;
        errors  = 0;
        passed  = 0;
        failed  = 0;
        m_ring  = '0;
        m_valid = '0;
        m_mode  = ibuf_pkg::LD_BOTH;
        void'($urandom(25));
        build_table();

        n = 0;
        while (rst_i !== 1'b0 && n < RST_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_i !== 1'b0) begin
            $display("reset still asserted after %0d cycles", n);
            $display("test failed");
            $finish;
        end
        #1;
        check_mask("valid_o", '0, valid_o);
        if (errors == 0) begin
            $display("reset: ok");
            passed++;
        end else begin
            $display("reset: FAIL");
            failed++;
        end
        #1;

        for (int i = 0; i < rows.size(); i++) begin
            row_err = errors;
            fetch1  = rows[i].f1;
            fetch2  = rows[i].f2;
            #30;  // loaded flags settle within the cycle
            check_flag("even_loaded_o", rows[i].exp_even, even_loaded_o);
            check_flag("odd_loaded_o", rows[i].exp_odd, odd_loaded_o);
            model_step(rows[i]);
            wait_edge();
            if (!edge_seen) begin
                $display("no clock edge within %0d ns at row %0d", EDGE_LIMIT, i);
                $display("test failed");
                $finish;
            end
            check_mask("valid_o", rows[i].exp_valid, valid_o);
            check_window("window_o", expect_window(rows[i].f2.new_bip), window_o);
            if (errors == row_err) begin
                $display("row %0d %s: ok", i, names[i]);
                passed++;
            end else begin
                $display("row %0d %s: FAIL", i, names[i]);
                failed++;
            end
            #1;
        end

        $display("tests run %0d, good %0d, bad %0d, mismatches %0d",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
src/fetch_pkg.sv
src/ibuf_pkg.sv
src/ibuf_load_ctrl.sv
src/ibuf_load_select.sv
src/ibuf_slots.sv
src/ibuf_window.sv
src/ibuf_top.sv
sim/ibuf_tb.sv

// ==== Bender.yml ====
package:
  name: ibuf

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/fetch_pkg.sv
      - src/ibuf_pkg.sv
      - src/ibuf_load_ctrl.sv
      - src/ibuf_load_select.sv
      - src/ibuf_slots.sv
      - src/ibuf_window.sv
      - src/ibuf_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - sim/ibuf_tb.sv
